// File: files.f
source/tomasulo_pkg.sv
source/register_status.sv
source/reservation_station.sv
source/alu_unit.sv
source/reorder_buffer.sv
source/ooo_backend.sv
testbench/ooo_backend_sva.sv
testbench/ooo_backend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ooo_backend_tb -f files.f \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vooo_backend_tb)"
echo "$out"
echo "$out" | grep -qxF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: source/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  issue_valid,
    input  tomasulo_pkg::opcode_t  issue_op,
    input  tomasulo_pkg::word_t    issue_a,
    input  tomasulo_pkg::word_t    issue_b,
    input  tomasulo_pkg::word_t    issue_imm,
    input  tomasulo_pkg::word_t    issue_pc,
    input  tomasulo_pkg::rob_tag_t issue_tag,
    // single result bus
    output logic                  cdb_valid,
    output tomasulo_pkg::rob_tag_t cdb_tag,
    output tomasulo_pkg::word_t    cdb_value,
    output logic                  cdb_taken
);

    import tomasulo_pkg::*;

    word_t result;
    logic  taken;

    always_comb begin
        taken = 1'b0;
        case (issue_op)
            op_add:  result = issue_a + issue_b;
            op_sub:  result = issue_a - issue_b;
            op_and:  result = issue_a & issue_b;
            op_or:   result = issue_a | issue_b;
            op_xor:  result = issue_a ^ issue_b;
            op_addi: result = issue_a + issue_imm;
            op_beq: begin
                // branch target, resolved later at commit
                result = issue_pc + issue_imm;
                taken  = (issue_a == issue_b);
            end
            default: result = '0;
        endcase
    end

    // result in flight is dropped on flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag   <= issue_tag;
        cdb_value <= result;
        cdb_taken <= taken;
    end

endmodule : alu_unit

`default_nettype wire

// File: source/ooo_backend.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_backend #(
    parameter int rob_entries = tomasulo_pkg::ROB_ENTRIES_DEFAULT,
    parameter int rs_entries  = tomasulo_pkg::RS_ENTRIES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    // decoded instruction in
    input  logic                  dispatch_valid,
    input  tomasulo_pkg::opcode_t  dispatch_op,
    input  tomasulo_pkg::reg_idx_t dispatch_rd,
    input  tomasulo_pkg::reg_idx_t dispatch_rs1,
    input  tomasulo_pkg::reg_idx_t dispatch_rs2,
    input  tomasulo_pkg::word_t    dispatch_imm,
    input  tomasulo_pkg::word_t    dispatch_pc,
    output logic                  dispatch_ready,
    // architectural results
    output logic                  commit_valid,
    output tomasulo_pkg::reg_idx_t commit_rd,
    output tomasulo_pkg::word_t    commit_value,
    // front end restart
    output logic                  redirect_valid,
    output tomasulo_pkg::word_t    redirect_pc
);

    import tomasulo_pkg::*;

    logic     dispatch_fire;
    logic     rob_full;
    logic     rs_full;
    rob_tag_t rob_free_tag;
    rob_tag_t commit_tag;

    // renamed operands
    word_t    src1_value;
    rob_tag_t src1_tag;
    word_t    src2_value;
    rob_tag_t src2_tag;

    // station to alu
    logic     issue_valid;
    opcode_t  issue_op;
    word_t    issue_a;
    word_t    issue_b;
    word_t    issue_imm;
    word_t    issue_pc;
    rob_tag_t issue_tag;

    // common data bus
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;
    logic     cdb_taken;

    // no dispatch while the flush pulse is out
    assign dispatch_ready = !rob_full && !rs_full && !redirect_valid;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    register_status u_register_status (
        .clk          (clk),
        .rst          (rst),
        .flush        (redirect_valid),
        .dispatch_fire(dispatch_fire),
        .dispatch_rd  (dispatch_rd),
        .dispatch_rs1 (dispatch_rs1),
        .dispatch_rs2 (dispatch_rs2),
        .dispatch_tag (rob_free_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_tag   (commit_tag),
        .src1_value   (src1_value),
        .src1_tag     (src1_tag),
        .src2_value   (src2_value),
        .src2_tag     (src2_tag)
    );

    reservation_station #(
        .rs_entries(rs_entries)
    ) u_reservation_station (
        .clk          (clk),
        .rst          (rst),
        .flush        (redirect_valid),
        .dispatch_fire(dispatch_fire),
        .dispatch_op  (dispatch_op),
        .dispatch_imm (dispatch_imm),
        .dispatch_pc  (dispatch_pc),
        .dispatch_tag (rob_free_tag),
        .src1_value   (src1_value),
        .src1_tag     (src1_tag),
        .src2_value   (src2_value),
        .src2_tag     (src2_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .rs_full      (rs_full),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_imm    (issue_imm),
        .issue_pc     (issue_pc),
        .issue_tag    (issue_tag)
    );

    alu_unit u_alu_unit (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect_valid),
        .issue_valid(issue_valid),
        .issue_op   (issue_op),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .issue_imm  (issue_imm),
        .issue_pc   (issue_pc),
        .issue_tag  (issue_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .cdb_taken  (cdb_taken)
    );

    reorder_buffer #(
        .rob_entries(rob_entries)
    ) u_reorder_buffer (
        .clk           (clk),
        .rst           (rst),
        .dispatch_fire (dispatch_fire),
        .dispatch_op   (dispatch_op),
        .dispatch_rd   (dispatch_rd),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .cdb_taken     (cdb_taken),
        .rob_full      (rob_full),
        .rob_free_tag  (rob_free_tag),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .commit_tag    (commit_tag),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

endmodule : ooo_backend

`default_nettype wire

// File: source/register_status.sv
`timescale 1ns/100ps
`default_nettype none

module register_status (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    // rename of the instruction being dispatched
    input  logic                  dispatch_fire,
    input  tomasulo_pkg::reg_idx_t dispatch_rd,
    input  tomasulo_pkg::reg_idx_t dispatch_rs1,
    input  tomasulo_pkg::reg_idx_t dispatch_rs2,
    input  tomasulo_pkg::rob_tag_t dispatch_tag,
    // result broadcast
    input  logic                  cdb_valid,
    input  tomasulo_pkg::rob_tag_t cdb_tag,
    input  tomasulo_pkg::word_t    cdb_value,
    // in-order retirement
    input  logic                  commit_valid,
    input  tomasulo_pkg::reg_idx_t commit_rd,
    input  tomasulo_pkg::word_t    commit_value,
    input  tomasulo_pkg::rob_tag_t commit_tag,
    // operand lookup
    output tomasulo_pkg::word_t    src1_value,
    output tomasulo_pkg::rob_tag_t src1_tag,
    output tomasulo_pkg::word_t    src2_value,
    output tomasulo_pkg::rob_tag_t src2_tag
);

    import tomasulo_pkg::*;

    // committed architectural state
    word_t    regs [32];
    // pending producer per register, 0 when the file holds the newest value
    rob_tag_t tags [32];
    // result already broadcast but not yet retired
    // needed since the producer will not appear on the cdb again
    word_t    spec_value [32];
    logic     spec_ready [32];

    reg_idx_t src_idx [2];
    word_t    src_val [2];
    rob_tag_t src_tg  [2];

    assign src_idx[0] = dispatch_rs1;
    assign src_idx[1] = dispatch_rs2;

    always_comb begin
        rob_tag_t tg;
        for (int s = 0; s < 2; s++) begin
            tg         = tags[src_idx[s]];
            src_val[s] = (src_idx[s] == '0) ? '0 : regs[src_idx[s]];
            src_tg[s]  = '0;
            if (src_idx[s] != '0 && tg != '0) begin
                if (spec_ready[src_idx[s]]) begin
                    src_val[s] = spec_value[src_idx[s]];
                end else if (cdb_valid && cdb_tag == tg) begin
                    // producer broadcasting this very cycle
                    src_val[s] = cdb_value;
                end else begin
                    src_tg[s] = tg;
                end
            end
        end
    end

    assign src1_value = src_val[0];
    assign src1_tag   = src_tg[0];
    assign src2_value = src_val[1];
    assign src2_tag   = src_tg[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r]       <= '0;
                tags[r]       <= '0;
                spec_ready[r] <= 1'b0;
            end
        end else begin
            // x0 never written
            if (commit_valid && commit_rd != '0) begin
                regs[commit_rd] <= commit_value;
            end
            if (flush) begin
                // committed values survive, speculation is dropped
                for (int r = 0; r < 32; r++) begin
                    tags[r]       <= '0;
                    spec_ready[r] <= 1'b0;
                end
            end else begin
                for (int r = 0; r < 32; r++) begin
                    if (cdb_valid && tags[r] != '0 && tags[r] == cdb_tag) begin
                        spec_ready[r] <= 1'b1;
                    end
                end
                // clear only if no younger writer renamed it meanwhile
                if (commit_valid && commit_rd != '0 && tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= '0;
                end
                // rename last so it wins over the commit clear
                if (dispatch_fire && dispatch_rd != '0) begin
                    tags[dispatch_rd]       <= dispatch_tag;
                    spec_ready[dispatch_rd] <= 1'b0;
                end
            end
        end
    end

    // speculative payload, qualified by spec_ready
    always_ff @(posedge clk) begin
        for (int r = 0; r < 32; r++) begin
            if (cdb_valid && tags[r] != '0 && tags[r] == cdb_tag) begin
                spec_value[r] <= cdb_value;
            end
        end
    end

endmodule : register_status

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_entries = tomasulo_pkg::ROB_ENTRIES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    // allocation at the tail
    input  logic                  dispatch_fire,
    input  tomasulo_pkg::opcode_t  dispatch_op,
    input  tomasulo_pkg::reg_idx_t dispatch_rd,
    // completion
    input  logic                  cdb_valid,
    input  tomasulo_pkg::rob_tag_t cdb_tag,
    input  tomasulo_pkg::word_t    cdb_value,
    input  logic                  cdb_taken,
    output logic                  rob_full,
    output tomasulo_pkg::rob_tag_t rob_free_tag,
    // retirement at the head
    output logic                  commit_valid,
    output tomasulo_pkg::reg_idx_t commit_rd,
    output tomasulo_pkg::word_t    commit_value,
    output tomasulo_pkg::rob_tag_t commit_tag,
    // taken branch, also the flush
    output logic                  redirect_valid,
    output tomasulo_pkg::word_t    redirect_pc
);

    import tomasulo_pkg::*;

    localparam int tag_w = $clog2(rob_entries);

    // entry 0 reserved, never allocated
    // free: !valid, waiting: valid && !done, finished: valid && done
    logic [rob_entries-1:0] valid;
    logic [rob_entries-1:0] done;
    opcode_t  op_q    [rob_entries];
    reg_idx_t rd_q    [rob_entries];
    word_t    value_q [rob_entries];
    logic     taken_q [rob_entries];

    rob_tag_t     head;
    rob_tag_t     tail;
    logic [tag_w:0] count;

    logic head_done;
    logic head_is_br;
    logic head_taken_br;
    logic retire;

    // wrap from the last entry back to 1
    function automatic rob_tag_t next_ptr(input rob_tag_t p);
        if (p == rob_tag_t'(rob_entries - 1)) begin
            next_ptr = rob_tag_t'(1);
        end else begin
            next_ptr = p + rob_tag_t'(1);
        end
    endfunction

    assign rob_full     = (count == (tag_w + 1)'(rob_entries - 1));
    assign rob_free_tag = tail;

    assign head_done     = valid[head] && done[head];
    assign head_is_br    = (op_q[head] == op_beq);
    assign head_taken_br = head_done && head_is_br && taken_q[head];
    // taken branch stays at the head until the flush
    assign retire        = head_done && !(head_is_br && taken_q[head]);

    // branches never write a register
    assign commit_valid = head_done && !head_is_br;
    assign commit_rd    = rd_q[head];
    assign commit_value = value_q[head];
    assign commit_tag   = head;

    always_ff @(posedge clk) begin
        if (rst || redirect_valid) begin
            valid          <= '0;
            done           <= '0;
            head           <= rob_tag_t'(1);
            tail           <= rob_tag_t'(1);
            count          <= '0;
            redirect_valid <= 1'b0;
        end else begin
            // one cycle pulse, the flush branch drops it again
            redirect_valid <= head_taken_br;
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                valid[head] <= 1'b0;
                done[head]  <= 1'b0;
                head        <= next_ptr(head);
            end
            if (dispatch_fire) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= next_ptr(tail);
            end
            if (dispatch_fire && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !dispatch_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // payload, qualified by valid and done
    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            op_q[tail] <= dispatch_op;
            rd_q[tail] <= dispatch_rd;
        end
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_value;
            taken_q[cdb_tag] <= cdb_taken;
        end
        // target sits in the value field of a beq
        if (head_taken_br) begin
            redirect_pc <= value_q[head];
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// File: source/reservation_station.sv
`timescale 1ns/100ps
`default_nettype none

module reservation_station #(
    parameter int rs_entries = tomasulo_pkg::RS_ENTRIES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    // dispatch with renamed operands
    input  logic                  dispatch_fire,
    input  tomasulo_pkg::opcode_t  dispatch_op,
    input  tomasulo_pkg::word_t    dispatch_imm,
    input  tomasulo_pkg::word_t    dispatch_pc,
    input  tomasulo_pkg::rob_tag_t dispatch_tag,
    input  tomasulo_pkg::word_t    src1_value,
    input  tomasulo_pkg::rob_tag_t src1_tag,
    input  tomasulo_pkg::word_t    src2_value,
    input  tomasulo_pkg::rob_tag_t src2_tag,
    // wakeup
    input  logic                  cdb_valid,
    input  tomasulo_pkg::rob_tag_t cdb_tag,
    input  tomasulo_pkg::word_t    cdb_value,
    output logic                  rs_full,
    // issue to the alu, never stalled
    output logic                  issue_valid,
    output tomasulo_pkg::opcode_t  issue_op,
    output tomasulo_pkg::word_t    issue_a,
    output tomasulo_pkg::word_t    issue_b,
    output tomasulo_pkg::word_t    issue_imm,
    output tomasulo_pkg::word_t    issue_pc,
    output tomasulo_pkg::rob_tag_t issue_tag
);

    import tomasulo_pkg::*;

    localparam int idx_w = $clog2(rs_entries);

    // per entry state
    logic [rs_entries-1:0] valid;
    opcode_t  op_q   [rs_entries];
    word_t    v1_q   [rs_entries];
    rob_tag_t t1_q   [rs_entries];
    word_t    v2_q   [rs_entries];
    rob_tag_t t2_q   [rs_entries];
    word_t    imm_q  [rs_entries];
    word_t    pc_q   [rs_entries];
    rob_tag_t dtag_q [rs_entries];

    logic [idx_w-1:0] free_sel;
    logic [idx_w-1:0] issue_sel;

    // scan downwards so the lowest index is the last one kept
    always_comb begin
        logic ready;
        free_sel    = '0;
        issue_sel   = '0;
        issue_valid = 1'b0;
        for (int e = rs_entries - 1; e >= 0; e--) begin
            // addi has no second register operand
            ready = valid[e] && t1_q[e] == '0 && (t2_q[e] == '0 || op_q[e] == op_addi);
            if (!valid[e]) begin
                free_sel = idx_w'(e);
            end
            if (ready) begin
                issue_sel   = idx_w'(e);
                issue_valid = 1'b1;
            end
        end
    end

    assign rs_full = &valid;

    assign issue_op  = op_q[issue_sel];
    assign issue_a   = v1_q[issue_sel];
    assign issue_b   = v2_q[issue_sel];
    assign issue_imm = imm_q[issue_sel];
    assign issue_pc  = pc_q[issue_sel];
    assign issue_tag = dtag_q[issue_sel];

    // occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[issue_sel] <= 1'b0;
            end
            // issuing slot is still busy, so free_sel never collides
            if (dispatch_fire) begin
                valid[free_sel] <= 1'b1;
            end
        end
    end

    // operands, tags and payload
    always_ff @(posedge clk) begin
        for (int e = 0; e < rs_entries; e++) begin
            if (cdb_valid && t1_q[e] != '0 && t1_q[e] == cdb_tag) begin
                v1_q[e] <= cdb_value;
                t1_q[e] <= '0;
            end
            if (cdb_valid && t2_q[e] != '0 && t2_q[e] == cdb_tag) begin
                v2_q[e] <= cdb_value;
                t2_q[e] <= '0;
            end
        end
        // sources already forwarded from the cdb by the lookup
        if (dispatch_fire) begin
            op_q[free_sel]   <= dispatch_op;
            v1_q[free_sel]   <= src1_value;
            t1_q[free_sel]   <= src1_tag;
            v2_q[free_sel]   <= src2_value;
            t2_q[free_sel]   <= src2_tag;
            imm_q[free_sel]  <= dispatch_imm;
            pc_q[free_sel]   <= dispatch_pc;
            dtag_q[free_sel] <= dispatch_tag;
        end
    end

endmodule : reservation_station

`default_nettype wire

// File: source/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    // data and pc width
    typedef logic [31:0] word_t;

    // architectural register index, x0 hardwired to zero
    typedef logic [4:0] reg_idx_t;

    // reorder buffer tag
    // sized for 8 entries, value 0 reserved for "no tag / value ready"
    typedef logic [2:0] rob_tag_t;

    // operations handled by the back end
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_addi = 3'd5,
        op_beq  = 3'd6
    } opcode_t;

    // defaults for the top level parameters
    // rob must match the width of rob_tag_t
    localparam int ROB_ENTRIES_DEFAULT = 8;
    localparam int RS_ENTRIES_DEFAULT  = 4;

endpackage : tomasulo_pkg

`default_nettype wire

// File: testbench/backend_trace.txt
# D op rd rs1 rs2 imm pc wrong_path / C rd value / R pc, all fields hex
# op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 addi, 6 beq
D 5 01 00 00 00000015 00000000 0
C 01 00000015
D 5 02 00 00 0000000c 00000004 0
C 02 0000000c
D 5 03 00 00 000007f0 00000008 0
C 03 000007f0
D 0 04 01 02 00000000 0000000c 0
C 04 00000021
D 1 05 01 02 00000000 00000010 0
C 05 00000009
D 2 06 01 02 00000000 00000014 0
C 06 00000004
D 3 07 01 02 00000000 00000018 0
C 07 0000001d
D 4 08 01 02 00000000 0000001c 0
C 08 00000019
# dependent chain, x9 rewritten while in flight
D 0 09 04 05 00000000 00000020 0
C 09 0000002a
D 1 09 09 02 00000000 00000024 0
C 09 0000001e
D 5 0a 09 00 ffffffff 00000028 0
C 0a 0000001d
D 4 09 0a 03 00000000 0000002c 0
C 09 000007ed
# long chain on x11 fills the station
D 5 0b 00 00 00000001 00000030 0
C 0b 00000001
D 0 0b 0b 0b 00000000 00000034 0
C 0b 00000002
D 0 0b 0b 0b 00000000 00000038 0
C 0b 00000004
D 0 0b 0b 0b 00000000 0000003c 0
C 0b 00000008
D 0 0b 0b 0b 00000000 00000040 0
C 0b 00000010
D 0 0b 0b 0b 00000000 00000044 0
C 0b 00000020
D 1 0c 0b 01 00000000 00000048 0
C 0c 0000000b
D 0 0b 0b 0c 00000000 0000004c 0
C 0b 0000002b
# not taken, no commit
D 6 00 01 02 00000040 00000050 0
D 5 0d 01 00 00000100 00000054 0
C 0d 00000115
# taken to 80, two wrong-path records
D 6 00 04 04 00000028 00000058 0
R 00000080
D 5 01 00 00 000003ff 0000005c 1
D 4 04 04 04 00000000 00000060 1
# target path reads the committed registers
D 0 0e 01 02 00000000 00000080 0
C 0e 00000021
D 3 0f 04 0d 00000000 00000084 0
C 0f 00000135
D 5 01 01 00 00000002 00000088 0
C 01 00000017
D 1 10 01 0e 00000000 0000008c 0
C 10 fffffff6

// File: testbench/ooo_backend_sva.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_backend_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   dispatch_ready,
    input logic                   commit_valid,
    input logic                   redirect_valid,
    input logic                   cdb_valid,
    input tomasulo_pkg::rob_tag_t cdb_tag
);

    // a branch never commits a register
    commit_vs_redirect: assert property (@(posedge clk) disable iff (rst)
        !(commit_valid && redirect_valid))
        else $error("commit and redirect high in the same cycle");

    // flush cycle blocks dispatch, then rob and station are free again
    no_dispatch_in_flush: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> !dispatch_ready ##1 dispatch_ready)
        else $error("dispatch_ready high during redirect or low after the flush");

    redirect_one_cycle: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid longer than one cycle");

    // tag 0 is reserved
    cdb_tag_nonzero: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> cdb_tag != '0)
        else $error("cdb broadcast with tag 0");

endmodule : ooo_backend_sva

bind ooo_backend ooo_backend_sva u_sva (
    .clk           (clk),
    .rst           (rst),
    .dispatch_ready(dispatch_ready),
    .commit_valid  (commit_valid),
    .redirect_valid(redirect_valid),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag)
);

`default_nettype wire

// File: testbench/ooo_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_backend_tb;

    import tomasulo_pkg::*;

    localparam string trace_path = "testbench/backend_trace.txt";

    logic     clk;
    logic     rst;
    logic     dispatch_valid;
    opcode_t  dispatch_op;
    reg_idx_t dispatch_rd;
    reg_idx_t dispatch_rs1;
    reg_idx_t dispatch_rs2;
    word_t    dispatch_imm;
    word_t    dispatch_pc;
    logic     dispatch_ready;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_value;
    logic     redirect_valid;
    word_t    redirect_pc;

    // dispatch records, in trace order
    int    d_op  [$];
    int    d_rd  [$];
    int    d_rs1 [$];
    int    d_rs2 [$];
    word_t d_imm [$];
    word_t d_pc  [$];
    int    d_wp  [$];
    // expected retirement events, C = commit, R = redirect
    byte   exp_kind [$];
    word_t exp_a    [$];
    word_t exp_b    [$];

    int          value_errors;
    int          other_errors;
    int          records;
    int          redirect_count;
    // redirects seen when the last right-path branch went out
    int          branch_redirects;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] rng_state;

    ooo_backend dut0 (
        .clk           (clk),
        .rst           (rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_op   (dispatch_op),
        .dispatch_rd   (dispatch_rd),
        .dispatch_rs1  (dispatch_rs1),
        .dispatch_rs2  (dispatch_rs2),
        .dispatch_imm  (dispatch_imm),
        .dispatch_pc   (dispatch_pc),
        .dispatch_ready(dispatch_ready),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one record per line, '#' lines are notes
    task automatic load_trace();
        int  fd;
        int  c;
        int  n;
        byte ch;
        int  f [7];
        fd = $fopen(trace_path, "r");
        assert (fd != 0) else begin
            other_errors++;
            $display("cannot open trace file %s", trace_path);
        end
        if (fd != 0) begin
            c = $fgetc(fd);
            while (c >= 0) begin
                ch = byte'(c);
                if (ch == "#") begin
                    while (c >= 0 && byte'(c) != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (ch == "D") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                                f[4], f[5], f[6]);
                    assert (n == 7) else begin
                        other_errors++;
                        $display("short dispatch record in trace");
                    end
                    d_op.push_back(f[0]);
                    d_rd.push_back(f[1]);
                    d_rs1.push_back(f[2]);
                    d_rs2.push_back(f[3]);
                    d_imm.push_back(word_t'(f[4]));
                    d_pc.push_back(word_t'(f[5]));
                    d_wp.push_back(f[6]);
                    records++;
                end else if (ch == "C") begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    exp_kind.push_back("C");
                    exp_a.push_back(word_t'(f[0]));
                    exp_b.push_back(word_t'(f[1]));
                    records++;
                end else if (ch == "R") begin
                    n = $fscanf(fd, "%h", f[0]);
                    exp_kind.push_back("R");
                    exp_a.push_back(word_t'(f[0]));
                    exp_b.push_back('0);
                    records++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // one trace instruction, held until accepted or dropped as wrong path
    task automatic drive_record(input int i);
        logic accepted;
        logic skipped;
        accepted = 1'b0;
        skipped  = 1'b0;
        // right path after a taken branch restarts after the redirect
        if (d_wp[i] == 0 && i > 0 && d_wp[i-1] != 0) begin
            while (redirect_count == branch_redirects) begin
                @(negedge clk);
            end
        end
        if (d_wp[i] == 0 && d_op[i] == int'(op_beq)) begin
            branch_redirects = redirect_count;
        end
        dispatch_op  = opcode_t'(3'(d_op[i]));
        dispatch_rd  = reg_idx_t'(d_rd[i]);
        dispatch_rs1 = reg_idx_t'(d_rs1[i]);
        dispatch_rs2 = reg_idx_t'(d_rs2[i]);
        dispatch_imm = d_imm[i];
        dispatch_pc  = d_pc[i];
        while (!accepted && !skipped) begin
            if (d_wp[i] != 0 && redirect_count != branch_redirects) begin
                skipped = 1'b1;
            end else begin
                dispatch_valid = 1'b1;
                // ready is stable between negedge and posedge
                accepted = dispatch_ready;
                @(negedge clk);
            end
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic check_commit();
        logic expected;
        expected = exp_kind.size() != 0 && exp_kind[0] == "C";
        assert (expected) else begin
            other_errors++;
            $display("%0t: commit of x%0d = %h arrived when no commit was expected",
                     $time, commit_rd, commit_value);
        end
        if (expected) begin
            assert (32'(commit_rd) == exp_a[0]) else begin
                value_errors++;
                $display("FAIL %0t commit_rd: got %0d, expected %0d",
                         $time, commit_rd, exp_a[0]);
            end
            assert (commit_value == exp_b[0]) else begin
                value_errors++;
                $display("FAIL %0t commit_value: got %h, expected %h",
                         $time, commit_value, exp_b[0]);
            end
            void'(exp_kind.pop_front());
            void'(exp_a.pop_front());
            void'(exp_b.pop_front());
        end
    endtask

    task automatic check_redirect();
        logic expected;
        expected = exp_kind.size() != 0 && exp_kind[0] == "R";
        assert (expected) else begin
            other_errors++;
            $display("%0t: redirect to %h arrived when no redirect was expected",
                     $time, redirect_pc);
        end
        if (expected) begin
            assert (redirect_pc == exp_a[0]) else begin
                value_errors++;
                $display("FAIL %0t redirect_pc: got %h, expected %h",
                         $time, redirect_pc, exp_a[0]);
            end
            void'(exp_kind.pop_front());
            void'(exp_a.pop_front());
            void'(exp_b.pop_front());
        end
    endtask

    task automatic finish_run();
        assert (exp_kind.size() == 0) else begin
            other_errors++;
            $display("%0d expected commit or redirect events never showed up",
                     exp_kind.size());
        end
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // retirement monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (commit_valid) begin
                check_commit();
            end
            if (redirect_valid) begin
                redirect_count++;
                check_redirect();
            end
        end
    end

    // cycle limit
    initial begin
        cycle_count = 0;
        @(posedge clk);
        cycle_count++;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", cycle_count);
        other_errors++;
        finish_run();
    end

    initial begin
        rst              = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_op      = op_add;
        dispatch_rd      = '0;
        dispatch_rs1     = '0;
        dispatch_rs2     = '0;
        dispatch_imm     = '0;
        dispatch_pc      = '0;
        value_errors     = 0;
        other_errors     = 0;
        records          = 0;
        redirect_count   = 0;
        branch_redirects = 0;
        rng_state        = 32'h985c_c916;
        load_trace();
        cycle_limit = 40 * records + 100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < d_op.size(); i++) begin
            // 0 to 2 idle cycles before each record
            rng_state = xorshift32(rng_state);
            repeat (rng_state % 3) @(negedge clk);
            drive_record(i);
        end
        while (exp_kind.size() != 0) begin
            @(negedge clk);
        end
        // catch stray commits after the last expected one
        repeat (20) @(negedge clk);
        finish_run();
    end

endmodule : ooo_backend_tb

`default_nettype wire
